//--- src/tracker_pkg.sv
package tracker_pkg;

    // ==================================================================
    // Vector types
    // ==================================================================

    // Raw D5M pixel
    typedef logic [11:0] pix_data_t;

    // Column and line inside a frame
    typedef logic [9:0]  coord_x_t;
    typedef logic [8:0]  coord_y_t;

    // Per-frame totals
    typedef logic [18:0] hit_count_t;
    typedef logic [28:0] sum_x_t;
    typedef logic [27:0] sum_y_t;

    // Captured frames since reset
    typedef logic [15:0] frame_count_t;

    // ==================================================================
    // Constants
    // ==================================================================

    // Object pixel when value at or above this
    localparam pix_data_t detect_threshold = 12'hC00;

    // Smallest blob taken as a real target
    localparam hit_count_t min_hits = 19'd16;

    // Miss frames in a row before the target is dropped
    localparam logic [2:0] lost_frames = 3'd4;

    // ==================================================================
    // Bundles
    // ==================================================================

    // One decoded pixel
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        logic     dval;
        logic     hit;
    } pixel_t;

    // Frame centroid
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } centroid_t;

    // Tracked target as seen by the outside
    typedef struct packed {
        centroid_t pos;
        logic      on_screen;
    } target_t;

endpackage

//--- src/pixel_decode.sv
`timescale 1ns/1ps

module pixel_decode (
    input  logic                     D5M_PIXLCLK,
    input  logic                     rst,
    input  tracker_pkg::pix_data_t   d5m_d,
    input  logic                     d5m_fval,
    input  logic                     d5m_lval,
    input  logic                     start,
    input  logic                     stop,
    output tracker_pkg::pixel_t      pixel,
    output logic                     frame_end,
    output tracker_pkg::frame_count_t frame_count
);
    import tracker_pkg::*;

    // Pin registers
    pix_data_t d_r;
    logic      fval_r;
    logic      lval_r;

    // One more stage for edge detection
    logic      fval_d;
    logic      lval_d;

    // Capture control
    logic      armed;
    logic      capture;
    logic      capture_now;

    logic      fval_rise;
    logic      fval_fall;
    logic      lval_rise;
    logic      lval_fall;

    // ==================================================================
    // Camera input stage
    // ==================================================================

    // Pixel data is payload only
    always_ff @(posedge D5M_PIXLCLK)
    begin
        d_r <= d5m_d;
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            fval_r <= 1'b0;
            lval_r <= 1'b0;
            fval_d <= 1'b0;
            lval_d <= 1'b0;
        end
        else
        begin
            fval_r <= d5m_fval;
            lval_r <= d5m_lval;
            fval_d <= fval_r;
            lval_d <= lval_r;
        end
    end

    assign fval_rise = fval_r & ~fval_d;
    assign fval_fall = ~fval_r & fval_d;
    assign lval_rise = lval_r & ~lval_d;
    assign lval_fall = ~lval_r & lval_d;

    // Decision for a new frame is taken on its first cycle
    assign capture_now = fval_rise ? armed : capture;

    // ==================================================================
    // Capture control and counting
    // ==================================================================

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            armed       <= 1'b0;
            capture     <= 1'b0;
            pixel       <= '0;
            frame_end   <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            // Stop wins over a coincident start
            if (stop)
                armed <= 1'b0;
            else if (start)
                armed <= 1'b1;

            // Frame capture only changes at frame edges
            if (fval_rise)
                capture <= armed;
            else if (fval_fall)
                capture <= 1'b0;

            // Column restarts per line
            if (lval_rise)
                pixel.x <= '0;
            else if (lval_r)
                pixel.x <= pixel.x + 1'b1;

            // Line restarts per frame, steps at end of line
            if (fval_rise)
                pixel.y <= '0;
            else if (lval_fall)
                pixel.y <= pixel.y + 1'b1;

            pixel.dval <= fval_r & lval_r & capture_now;
            pixel.hit  <= fval_r & lval_r & capture_now & (d_r >= detect_threshold);

            frame_end <= fval_fall & capture;
            if (frame_end)
                frame_count <= frame_count + 1'b1;
        end
    end

    // A frame is at least two cycles long
    assert property (@(posedge D5M_PIXLCLK) disable iff (rst)
        frame_end |=> !frame_end);

endmodule

//--- src/centroid_accum.sv
`timescale 1ns/1ps

module centroid_accum (
    input  logic                    D5M_PIXLCLK,
    input  logic                    rst,
    input  tracker_pkg::pixel_t     pixel,
    input  logic                    frame_end,
    output logic                    div_start,
    output logic                    miss,
    output tracker_pkg::sum_x_t     sum_x,
    output tracker_pkg::sum_y_t     sum_y,
    output tracker_pkg::hit_count_t hits
);
    import tracker_pkg::*;

    // Running totals for the frame in progress
    sum_x_t     acc_x;
    sum_y_t     acc_y;
    hit_count_t acc_n;

    // Object pixel of the current cycle
    logic       take;

    // Enough pixels for a centroid
    logic       enough;

    assign take   = pixel.dval & pixel.hit;
    assign enough = (acc_n >= min_hits);

    // ==================================================================
    // Accumulators
    // ==================================================================

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            acc_x <= '0;
            acc_y <= '0;
            acc_n <= '0;
        end
        else if (frame_end)
        begin
            // Fresh start for the next frame
            acc_x <= '0;
            acc_y <= '0;
            acc_n <= '0;
        end
        else if (take)
        begin
            acc_x <= acc_x + sum_x_t'(pixel.x);
            acc_y <= acc_y + sum_y_t'(pixel.y);
            acc_n <= acc_n + 1'b1;
        end
    end

    // ==================================================================
    // Frame-end hand-off
    // ==================================================================

    // Totals stay put until the next frame ends
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (frame_end)
        begin
            sum_x <= acc_x;
            sum_y <= acc_y;
            hits  <= acc_n;
        end
    end

    // Either a divide or a miss, one cycle after frame end
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            div_start <= 1'b0;
            miss      <= 1'b0;
        end
        else
        begin
            div_start <= frame_end & enough;
            miss      <= frame_end & ~enough;
        end
    end

    assert property (@(posedge D5M_PIXLCLK) disable iff (rst)
        !(div_start && miss));

endmodule

//--- src/centroid_divider.sv
`timescale 1ns/1ps

module centroid_divider (
    input  logic                    D5M_PIXLCLK,
    input  logic                    rst,
    input  logic                    div_start,
    input  tracker_pkg::sum_x_t     sum_x,
    input  tracker_pkg::sum_y_t     sum_y,
    input  tracker_pkg::hit_count_t hits,
    output logic                    cent_val,
    output tracker_pkg::centroid_t  cent
);
    import tracker_pkg::*;

    typedef enum logic [1:0] {IDLE, DIV_X, DIV_Y} div_state_t;

    div_state_t state;
    logic [4:0] step;
    logic       fin;

    // Dividend shifts out at the top, quotient enters at the bottom
    sum_x_t     dvd;
    hit_count_t rem;
    hit_count_t divisor;
    sum_y_t     sum_y_q;
    coord_x_t   quot_x;

    // One restoring step
    logic [$bits(hit_count_t):0] partial;
    logic                        q_bit;
    hit_count_t                  rem_next;

    always_comb
    begin
        partial  = {rem, dvd[$bits(sum_x_t)-1]};
        q_bit    = (partial >= {1'b0, divisor});
        rem_next = q_bit ? hit_count_t'(partial - {1'b0, divisor})
                         : partial[$bits(hit_count_t)-1:0];
    end

    // ==================================================================
    // Sequencer
    // ==================================================================

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            state    <= IDLE;
            step     <= '0;
            fin      <= 1'b0;
            cent_val <= 1'b0;
            cent     <= '0;
        end
        else
        begin
            fin      <= 1'b0;
            cent_val <= fin;
            // Both quotients leave together
            if (fin)
                cent <= '{x: quot_x, y: dvd[$bits(coord_y_t)-1:0]};
            case (state)
                IDLE:
                begin
                    if (div_start)
                    begin
                        state <= DIV_X;
                        step  <= 5'($bits(sum_x_t) - 1);
                    end
                end
                DIV_X:
                begin
                    step <= step - 1'b1;
                    if (step == '0)
                    begin
                        state <= DIV_Y;
                        step  <= 5'($bits(sum_y_t) - 1);
                    end
                end
                DIV_Y:
                begin
                    step <= step - 1'b1;
                    if (step == '0)
                    begin
                        state <= IDLE;
                        fin   <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ==================================================================
    // Datapath
    // ==================================================================

    always_ff @(posedge D5M_PIXLCLK)
    begin
        case (state)
            IDLE:
            begin
                if (div_start)
                begin
                    dvd     <= sum_x;
                    rem     <= '0;
                    divisor <= hits;
                    sum_y_q <= sum_y;
                end
            end
            DIV_X:
            begin
                if (step == '0)
                begin
                    // Keep x, then left-align y in the shifter
                    quot_x <= {dvd[$bits(coord_x_t)-2:0], q_bit};
                    dvd    <= {sum_y_q, 1'b0};
                    rem    <= '0;
                end
                else
                begin
                    dvd <= {dvd[$bits(sum_x_t)-2:0], q_bit};
                    rem <= rem_next;
                end
            end
            DIV_Y:
            begin
                dvd <= {dvd[$bits(sum_x_t)-2:0], q_bit};
                rem <= rem_next;
            end
            default:
            begin
                rem <= '0;
            end
        endcase
    end

    // Frames must not end faster than one division
    assert property (@(posedge D5M_PIXLCLK) disable iff (rst)
        div_start |-> (state == IDLE));

endmodule

//--- src/target_tracker.sv
`timescale 1ns/1ps

module target_tracker (
    input  logic                   D5M_PIXLCLK,
    input  logic                   rst,
    input  logic                   cent_val,
    input  tracker_pkg::centroid_t cent,
    input  logic                   miss,
    output tracker_pkg::target_t   target,
    output logic                   target_valid
);
    import tracker_pkg::*;

    // Misses in a row, saturates at the drop count
    logic [2:0] miss_cnt;

    // Next miss is the one that drops the target
    logic       last_miss;

    assign last_miss = (miss_cnt >= lost_frames - 3'd1);

    // ==================================================================
    // Target state
    // ==================================================================

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (rst)
        begin
            target       <= '0;
            miss_cnt     <= '0;
            target_valid <= 1'b0;
        end
        else
        begin
            // Every frame result is an update
            target_valid <= cent_val | miss;

            if (cent_val)
            begin
                // Fresh centroid
                target.pos       <= cent;
                target.on_screen <= 1'b1;
                miss_cnt         <= '0;
            end
            else if (miss)
            begin
                if (miss_cnt != lost_frames)
                    miss_cnt <= miss_cnt + 1'b1;
                // Last known position is kept
                if (last_miss)
                    target.on_screen <= 1'b0;
            end
        end
    end

endmodule

//--- src/object_tracker_top.sv
`timescale 1ns/1ps

module object_tracker_top (
    input  logic                      D5M_PIXLCLK,
    input  logic                      rst,
    input  tracker_pkg::pix_data_t    D5M_D,
    input  logic                      D5M_FVAL,
    input  logic                      D5M_LVAL,
    input  logic                      start,
    input  logic                      stop,
    output tracker_pkg::target_t      target,
    output logic                      target_valid,
    output tracker_pkg::frame_count_t frame_count
);
    import tracker_pkg::*;

    // ==================================================================
    // Pipeline wires
    // ==================================================================

    pixel_t     pixel;
    logic       frame_end;
    logic       div_start;
    logic       miss;
    sum_x_t     sum_x;
    sum_y_t     sum_y;
    hit_count_t hits;
    logic       cent_val;
    centroid_t  cent;

    // Pins to classified pixels
    pixel_decode pixel_decode_i (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst         (rst),
        .d5m_d       (D5M_D),
        .d5m_fval    (D5M_FVAL),
        .d5m_lval    (D5M_LVAL),
        .start       (start),
        .stop        (stop),
        .pixel       (pixel),
        .frame_end   (frame_end),
        .frame_count (frame_count)
    );

    // Frame sums
    centroid_accum centroid_accum_i (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst         (rst),
        .pixel       (pixel),
        .frame_end   (frame_end),
        .div_start   (div_start),
        .miss        (miss),
        .sum_x       (sum_x),
        .sum_y       (sum_y),
        .hits        (hits)
    );

    // Sums to mean position
    centroid_divider centroid_divider_i (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst         (rst),
        .div_start   (div_start),
        .sum_x       (sum_x),
        .sum_y       (sum_y),
        .hits        (hits),
        .cent_val    (cent_val),
        .cent        (cent)
    );

    // Held target and on-screen flag
    target_tracker target_tracker_i (
        .D5M_PIXLCLK  (D5M_PIXLCLK),
        .rst          (rst),
        .cent_val     (cent_val),
        .cent         (cent),
        .miss         (miss),
        .target       (target),
        .target_valid (target_valid)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 200 ns pixel clock
    initial
    begin
        clk = 1'b0;
        forever #100 clk = ~clk;
    end

    // Reset held for the first 8 rising edges
    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- sim/tb_object_tracker.sv
`timescale 1ns/1ps

module tb_object_tracker;
    import tracker_pkg::*;

    // One frame: object rectangle, pixel levels, capture strobes
    typedef struct packed {
        logic [5:0] x0;
        logic [5:0] y0;
        logic [5:0] w;
        logic [5:0] h;
        pix_data_t  obj;
        pix_data_t  bg;
        logic       arm;
        logic       disarm;
    } frame_row_t;

    localparam int n_rows         = 15;
    localparam int frame_cols     = 32;
    localparam int frame_lines    = 12;
    localparam int line_blank     = 8;
    localparam int frame_blank    = 80;
    localparam int timeout_cycles = n_rows * 600 + 200;

    frame_row_t   table_rows [n_rows];

    logic         D5M_PIXLCLK;
    logic         rst;
    pix_data_t    d5m_d;
    logic         d5m_fval;
    logic         d5m_lval;
    logic         start;
    logic         stop;
    target_t      target;
    logic         target_valid;
    frame_count_t frame_count;

    // Reference model of capture and target state
    logic         armed;
    centroid_t    exp_pos;
    logic         exp_on;
    int           exp_misses;
    frame_count_t exp_frames;

    int           errors;
    int           checks;
    int           cycles;

    tb_clock tb_clock_i (
        .clk (D5M_PIXLCLK),
        .rst (rst)
    );

    object_tracker_top object_tracker_top_i (
        .D5M_PIXLCLK  (D5M_PIXLCLK),
        .rst          (rst),
        .D5M_D        (d5m_d),
        .D5M_FVAL     (d5m_fval),
        .D5M_LVAL     (d5m_lval),
        .start        (start),
        .stop         (stop),
        .target       (target),
        .target_valid (target_valid),
        .frame_count  (frame_count)
    );

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Object level inside the rectangle, random dark level outside
    function automatic pix_data_t pixel_value(input frame_row_t r, input int col,
                                              input int line);
        logic in_rect;
        in_rect = (col >= int'(r.x0)) && (col < int'(r.x0) + int'(r.w))
               && (line >= int'(r.y0)) && (line < int'(r.y0) + int'(r.h));
        if (in_rect)
            return r.obj;
        else
            return pix_data_t'($urandom % 32'(r.bg));
    endfunction

    // Floor of mean column and mean line over the rectangle
    function automatic centroid_t rect_mean(input frame_row_t r);
        int        sx;
        int        sy;
        int        n;
        centroid_t c;
        sx = 0;
        sy = 0;
        n  = 0;
        for (int yy = int'(r.y0); yy < int'(r.y0) + int'(r.h); yy++)
        begin
            for (int xx = int'(r.x0); xx < int'(r.x0) + int'(r.w); xx++)
            begin
                sx += xx;
                sy += yy;
                n++;
            end
        end
        c.x = coord_x_t'(sx / n);
        c.y = coord_y_t'(sy / n);
        return c;
    endfunction

    task automatic fill_table();
        // Bright blob before any start strobe
        table_rows[0]  = '{6'd10, 6'd3, 6'd4, 6'd4, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        table_rows[1]  = '{6'd10, 6'd3, 6'd4, 6'd4, 12'hFFF, 12'hC00, 1'b1, 1'b0};
        // Four misses: too small, one below threshold, empty, too small
        table_rows[2]  = '{6'd5, 6'd5, 6'd3, 6'd5, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        table_rows[3]  = '{6'd20, 6'd2, 6'd6, 6'd4, 12'hBFF, 12'hC00, 1'b0, 1'b0};
        table_rows[4]  = '{6'd0, 6'd0, 6'd0, 6'd0, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        table_rows[5]  = '{6'd1, 6'd1, 6'd2, 6'd2, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        // Edges: column 0, last column, last line at exact threshold
        table_rows[6]  = '{6'd0, 6'd0, 6'd4, 6'd6, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        table_rows[7]  = '{6'd28, 6'd0, 6'd4, 6'd5, 12'hFFF, 12'h800, 1'b0, 1'b0};
        table_rows[8]  = '{6'd12, 6'd8, 6'd5, 6'd4, 12'hC00, 12'hC00, 1'b0, 1'b0};
        // Stopped, then still stopped
        table_rows[9]  = '{6'd10, 6'd3, 6'd4, 6'd4, 12'hFFF, 12'hC00, 1'b0, 1'b1};
        table_rows[10] = '{6'd10, 6'd3, 6'd4, 6'd4, 12'hFFF, 12'hC00, 1'b0, 1'b0};
        // Restarted
        table_rows[11] = '{6'd7, 6'd2, 6'd9, 6'd7, 12'hFFF, 12'hC00, 1'b1, 1'b0};
        table_rows[12] = '{6'd30, 6'd0, 6'd2, 6'd12, 12'hE00, 12'hC00, 1'b0, 1'b0};
        table_rows[13] = '{6'd0, 6'd11, 6'd32, 6'd1, 12'hFFF, 12'h400, 1'b0, 1'b0};
        // Single miss keeps the target on screen
        table_rows[14] = '{6'd29, 6'd9, 6'd3, 6'd3, 12'hFFF, 12'hC00, 1'b0, 1'b0};
    endtask

    // ==================================================================
    // Frame driver and result checks
    // ==================================================================

    task automatic drive_frame(input frame_row_t r);
        // Strobes land in blanking, ahead of FVAL
        @(posedge D5M_PIXLCLK);
        start <= r.arm;
        stop  <= r.disarm;
        @(posedge D5M_PIXLCLK);
        start <= 1'b0;
        stop  <= 1'b0;
        @(posedge D5M_PIXLCLK);
        d5m_fval <= 1'b1;
        for (int line = 0; line < frame_lines; line++)
        begin
            for (int col = 0; col < frame_cols; col++)
            begin
                @(posedge D5M_PIXLCLK);
                d5m_lval <= 1'b1;
                d5m_d    <= pixel_value(r, col, line);
            end
            for (int k = 0; k < line_blank; k++)
            begin
                @(posedge D5M_PIXLCLK);
                d5m_lval <= 1'b0;
                d5m_d    <= '0;
            end
        end
        @(posedge D5M_PIXLCLK);
        d5m_fval <= 1'b0;
    endtask

    task automatic watch_result(input int idx, input frame_row_t r);
        int   updates;
        int   n;
        logic captured;
        updates = 0;
        // Result is due within the frame blanking
        for (int k = 0; k < frame_blank; k++)
        begin
            @(negedge D5M_PIXLCLK);
            if (target_valid)
                updates++;
        end

        // Expected outcome of this frame
        if (r.disarm)
            armed = 1'b0;
        else if (r.arm)
            armed = 1'b1;
        captured = armed;
        n = (r.obj >= detect_threshold) ? int'(r.w) * int'(r.h) : 0;
        if (captured)
        begin
            exp_frames++;
            if (n >= int'(min_hits))
            begin
                exp_pos    = rect_mean(r);
                exp_on     = 1'b1;
                exp_misses = 0;
            end
            else
            begin
                if (exp_misses < int'(lost_frames))
                    exp_misses++;
                if (exp_misses >= int'(lost_frames))
                    exp_on = 1'b0;
            end
        end

        check_value($sformatf("frame %0d target_valid pulses", idx), 32'(updates),
                    captured ? 32'd1 : 32'd0);
        check_value($sformatf("frame %0d target.pos.x", idx), 32'(target.pos.x),
                    32'(exp_pos.x));
        check_value($sformatf("frame %0d target.pos.y", idx), 32'(target.pos.y),
                    32'(exp_pos.y));
        check_value($sformatf("frame %0d target.on_screen", idx), 32'(target.on_screen),
                    32'(exp_on));
        check_value($sformatf("frame %0d frame_count", idx), 32'(frame_count),
                    32'(exp_frames));
    endtask

    // ==================================================================
    // Watchdog
    // ==================================================================

    always @(posedge D5M_PIXLCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("Timeout: stimulus still running after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        d5m_d      = '0;
        d5m_fval   = 1'b0;
        d5m_lval   = 1'b0;
        start      = 1'b0;
        stop       = 1'b0;
        armed      = 1'b0;
        exp_pos    = '0;
        exp_on     = 1'b0;
        exp_misses = 0;
        exp_frames = '0;
        void'($urandom(32'ha100));
        fill_table();

        // State right after reset
        @(negedge D5M_PIXLCLK);
        while (rst)
            @(negedge D5M_PIXLCLK);
        check_value("target_valid", 32'(target_valid), 32'h0);
        check_value("target.on_screen", 32'(target.on_screen), 32'h0);
        check_value("frame_count", 32'(frame_count), 32'h0);

        for (int i = 0; i < n_rows; i++)
        begin
            drive_frame(table_rows[i]);
            watch_result(i, table_rows[i]);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
src/tracker_pkg.sv
src/pixel_decode.sv
src/centroid_accum.sv
src/centroid_divider.sv
src/target_tracker.sv
src/object_tracker_top.sv
sim/tb_clock.sv
sim/tb_object_tracker.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the object tracker testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_object_tracker \
    -f all.f \
    -o sim_tracker

./obj_dir/sim_tracker | tee sim.log

if grep -qxF "** PASS **" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
